/* hdl/samc_defines.svh */
//==========================================================
// Port numbers and timing constants of the ASIC glue
// Divider counts assume clk_sys at 96 times the 1 MHz rate
//==========================================================

`ifndef SAMC_DEFINES_SVH
`define SAMC_DEFINES_SVH

// External RAM page registers
`define SAMC_PORT_EXT_C     128
`define SAMC_PORT_EXT_D     129

// Parallel port used as a stereo DAC
`define SAMC_PORT_LPT_DATA  232
`define SAMC_PORT_LPT_STB   233

// ASIC registers
`define SAMC_PORT_STATUS    249
`define SAMC_PORT_LMPR      250
`define SAMC_PORT_HMPR      251
`define SAMC_PORT_MIDI      253
`define SAMC_PORT_BORDER    254

// clk_sys cycles per 1 MHz enable
`define SAMC_MEG_DIV        96

// MIDI byte time in 1 MHz ticks, and where the interrupt starts
`define SAMC_MIDI_TX_TIME   319
`define SAMC_MIDI_INT_AT    15

// SID muter step per 1 MHz tick
`define SAMC_MUTE_STEP      1

`endif

/* hdl/samc_pkg.sv */
//==========================================================
// Shared types of the ASIC glue
//==========================================================

`default_nettype none

package samc_pkg;

	// Internal RAM page, 32 pages of 16K
	typedef logic [4:0] page_t;

	// Bit 8 set selects external RAM, low bits are its page
	typedef logic [8:0] ram_page_t;

	// CPU speed code, 0 to 5
	typedef logic [2:0] cpu_speed_t;

	// Port data and register byte
	typedef logic [7:0] port_byte_t;

	// Signed SID sample as delivered by the SID core
	typedef logic [17:0] sid_sample_t;

	// Unsigned audio output sample
	typedef logic [15:0] audio_t;

endpackage

`default_nettype wire

/* hdl/cpu_clock_gen.sv */
//==========================================================
// CPU, 1 MHz and 6 MHz clock enables with contention waits
// Speed codes above 5 run at speed 5
// A speed change waits for an idle bus and two counter wraps
//==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "samc_defines.svh"

module cpu_clock_gen
	import samc_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_speed_t speed_req,
	input  logic       rd_n,
	input  logic       wr_n,
	input  logic       iorq_n,
	input  logic       m1_n,
	input  logic       ram_acc,
	input  logic       mem_contention,
	input  logic       io_contention,
	input  logic       ram_busy,
	input  logic [4:0] addr_hi5,
	output logic       ce_cpu_p,
	output logic       ce_cpu_n,
	output logic       ce_1m,
	output logic       ce_6m
);

	// Divider wrap and mid points per speed
	localparam logic [4:0] cpu_max [6] = '{5'd26, 5'd15, 5'd15, 5'd9, 5'd7, 5'd3};
	localparam logic [4:0] cpu_mid [6] = '{5'd13, 5'd8, 5'd8, 5'd5, 5'd4, 5'd2};

	cpu_speed_t cpu_speed;
	cpu_speed_t req_speed;
	logic [3:0] counter;
	logic [4:0] cpu_div;
	logic [6:0] meg_div;
	logic [4:0] div_max;
	logic [4:0] div_mid;
	logic       cnt_en;
	logic       skip;
	logic       cpu_en;
	logic       cpu_p;
	logic       cpu_n;
	logic       div_hold;
	logic       speed_change;
	logic       io_acc;
	logic       ram_wait;
	logic       io_wait;
	logic       old_ram;
	logic       old_io;
	logic       old_memcont;
	logic       old_iocont;

	assign req_speed = (speed_req > 3'd5) ? 3'd5 : speed_req;
	assign div_max   = cpu_max[cpu_speed];
	assign div_mid   = cpu_mid[cpu_speed];

	// SDRAM stall parks the divider at mid count on fast speeds
	assign div_hold     = ram_busy && (cpu_speed >= 3'd3) && (cpu_div == div_mid);
	assign speed_change = (cpu_speed != req_speed) && rd_n && wr_n && ce_cpu_p;

	assign ce_cpu_p = cpu_en & cpu_p;
	assign ce_cpu_n = cpu_en & cpu_n;

	//==========================================================
	// Fixed rate enables
	//==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			meg_div <= '0;
			ce_6m   <= 1'b0;
			ce_1m   <= 1'b0;
		end else begin
			counter <= counter + 4'd1;
			ce_6m   <= (counter == 4'd0);
			if (meg_div == 7'(`SAMC_MEG_DIV - 1))
				meg_div <= '0;
			else
				meg_div <= meg_div + 7'd1;
			ce_1m <= (meg_div == 7'd0);
		end
	end

	//==========================================================
	// CPU divider and speed switch
	//==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cpu_speed <= '0;
			cpu_div   <= '0;
			cnt_en    <= 1'b1;
			skip      <= 1'b0;
			cpu_en    <= 1'b1;
			cpu_p     <= 1'b0;
			cpu_n     <= 1'b0;
		end else begin
			cpu_p <= 1'b0;
			cpu_n <= 1'b0;
			if (cnt_en && !div_hold) begin
				if (cpu_div >= div_max)
					cpu_div <= '0;
				else
					cpu_div <= cpu_div + 5'd1;
				// At speed 1 a pending wait swallows a whole CPU cycle
				if (cpu_div == 5'd0)
					cpu_en <= !((cpu_speed == 3'd1) && (ram_wait || io_wait));
				cpu_p <= (cpu_div == 5'd0);
				cpu_n <= (cpu_div == div_mid);
			end

			if (speed_change) begin
				cpu_div <= 5'd1;
				cnt_en  <= 1'b0;
				skip    <= 1'b0;
			end

			// Resume on the second wrap of the free counter
			if (!cnt_en && (counter == 4'd0)) begin
				skip <= 1'b1;
				if (skip) begin
					cpu_speed <= req_speed;
					cnt_en    <= 1'b1;
				end
			end
		end
	end

	//==========================================================
	// Contention waits
	//==========================================================
	assign io_acc = !iorq_n && !(rd_n && wr_n) && m1_n && (&addr_hi5);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_wait    <= 1'b0;
			io_wait     <= 1'b0;
			old_ram     <= 1'b0;
			old_io      <= 1'b0;
			old_memcont <= 1'b0;
			old_iocont  <= 1'b0;
		end else begin
			old_ram     <= ram_acc;
			old_io      <= io_acc;
			old_memcont <= mem_contention;
			old_iocont  <= io_contention;
			if (!old_ram && ram_acc && mem_contention)
				ram_wait <= 1'b1;
			if (old_memcont && !mem_contention)
				ram_wait <= 1'b0;
			if (!old_io && io_acc && io_contention)
				io_wait <= 1'b1;
			if (old_iocont && !io_contention)
				io_wait <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/asic_ports.sv */
//==========================================================
// ASIC and external RAM page registers with read-back
// Only addr[7:0] decodes a port; writes act on the
// rising edge of the I/O write condition
//==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "samc_defines.svh"

module asic_ports
	import samc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        iorq_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic [15:0] addr,
	input  port_byte_t  cpu_dout,
	input  logic        int_midi,
	output port_byte_t  lmpr,
	output port_byte_t  hmpr,
	output port_byte_t  ext_c,
	output port_byte_t  ext_d,
	output logic        ear,
	output logic        midi_wr_stb,
	output logic        lptd_wr_stb,
	output logic        lpts_wr_stb,
	output port_byte_t  asic_dout
);

	port_byte_t io_port;
	logic       port_we;
	logic       old_we;
	logic       we_rise;
	logic       border_ear;

	assign io_port = addr[7:0];
	assign port_we = !iorq_n && !wr_n && m1_n;
	assign we_rise = port_we && !old_we;

	// One pulse per bus write for the MIDI and DAC blocks
	assign midi_wr_stb = we_rise && (io_port == 8'(`SAMC_PORT_MIDI));
	assign lptd_wr_stb = we_rise && (io_port == 8'(`SAMC_PORT_LPT_DATA));
	assign lpts_wr_stb = we_rise && (io_port == 8'(`SAMC_PORT_LPT_STB));

	// Border keeps only the beeper bit
	assign ear = border_ear;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// No write edge is taken straight out of reset
			old_we     <= 1'b1;
			lmpr       <= '0;
			hmpr       <= '0;
			border_ear <= 1'b0;
		end else begin
			old_we <= port_we;
			if (we_rise) begin
				case (io_port)
					8'(`SAMC_PORT_LMPR):   lmpr       <= cpu_dout;
					8'(`SAMC_PORT_HMPR):   hmpr       <= cpu_dout;
					8'(`SAMC_PORT_BORDER): border_ear <= cpu_dout[4];
					default: ;
				endcase
			end
		end
	end

	// External RAM pages survive reset
	always_ff @(posedge clk_sys) begin
		if (we_rise && (io_port == 8'(`SAMC_PORT_EXT_C)))
			ext_c <= cpu_dout;
		if (we_rise && (io_port == 8'(`SAMC_PORT_EXT_D)))
			ext_d <= cpu_dout;
	end

	//==========================================================
	// Read-back
	//==========================================================
	always_comb begin
		case (io_port)
			// Frame, line and keyboard bits read inactive
			8'(`SAMC_PORT_STATUS):   asic_dout = {3'b111, !int_midi, 4'b1111};
			8'(`SAMC_PORT_LMPR):     asic_dout = lmpr;
			8'(`SAMC_PORT_HMPR):     asic_dout = hmpr;
			8'(`SAMC_PORT_LPT_DATA): asic_dout = 8'h00;
			8'(`SAMC_PORT_LPT_STB):  asic_dout = 8'h00;
			default:                 asic_dout = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/memory_pager.sv */
//==========================================================
// RAM paging, ROM select and write protect
// ext_ram_off is sampled only while reset is high
//==========================================================

`timescale 1ns/10ps
`default_nettype none

module memory_pager
	import samc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ext_ram_off,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        rfsh_n,
	input  logic [15:0] addr,
	input  port_byte_t  lmpr,
	input  port_byte_t  hmpr,
	input  port_byte_t  ext_c,
	input  port_byte_t  ext_d,
	output ram_page_t   ram_page,
	output logic        rom_sel,
	output logic        ram_we,
	output logic        ram_rd,
	output logic        ram_acc
);

	page_t page_ab;
	page_t page_cd;
	logic  rom0_sel;
	logic  rom1_sel;
	logic  ram_wp;
	logic  ext_ram;
	logic  ext_dis;
	logic  ext_ena;

	assign page_ab  = lmpr[4:0];
	assign page_cd  = hmpr[4:0];
	assign rom0_sel = !lmpr[5] && (addr[15:14] == 2'd0);
	assign rom1_sel = lmpr[6] && (addr[15:14] == 2'd3);
	assign ram_wp   = lmpr[7] && (addr[15:14] == 2'd0);
	assign ext_ram  = hmpr[7] && addr[15];
	assign ext_ena  = !(ext_ram && ext_dis);

	always_ff @(posedge clk_sys) begin
		if (reset)
			ext_dis <= ext_ram_off;
	end

	always_comb begin
		if (ext_ram)
			ram_page = addr[14] ? {1'b1, ext_d} : {1'b1, ext_c};
		else begin
			case (addr[15:14])
				2'd0:    ram_page = {4'd0, page_ab};
				2'd1:    ram_page = {4'd0, page_t'(page_ab + 5'd1)};
				2'd2:    ram_page = {4'd0, page_cd};
				default: ram_page = {4'd0, page_t'(page_cd + 5'd1)};
			endcase
		end
	end

	assign rom_sel = rom0_sel || rom1_sel;
	assign ram_we  = !(rom_sel || ram_wp) && !mreq_n && !wr_n && ext_ena;
	assign ram_rd  = !rom_sel && !mreq_n && !rd_n;

	// Internal RAM access, seen by the contention logic
	assign ram_acc = !mreq_n && rfsh_n && !rom_sel && !ext_ram;

endmodule

`default_nettype wire

/* hdl/midi_tx_timer.sv */
//==========================================================
// MIDI transmit timer, one byte time per port write
// No serial data is produced, only the busy level and IRQ
//==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "samc_defines.svh"

module midi_tx_timer (
	input  logic clk_sys,
	input  logic reset,
	input  logic ce_1m,
	input  logic midi_wr_stb,
	output logic midi_tx,
	output logic int_midi
);

	logic [8:0] tx_time;
	logic       pending;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tx_time  <= '0;
			pending  <= 1'b0;
			midi_tx  <= 1'b0;
			int_midi <= 1'b0;
		end else begin
			if (ce_1m) begin
				if (tx_time != 9'd0) begin
					tx_time <= tx_time - 9'd1;
					// Raise once the countdown reaches INT_AT
					if (tx_time == 9'(`SAMC_MIDI_INT_AT + 1))
						int_midi <= 1'b1;
				end else begin
					midi_tx  <= 1'b0;
					int_midi <= 1'b0;
					if (pending) begin
						midi_tx <= 1'b1;
						tx_time <= 9'(`SAMC_MIDI_TX_TIME);
						pending <= 1'b0;
					end
				end
			end
			// A write always wins over the pending clear
			if (midi_wr_stb)
				pending <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/lpt_dac.sv */
//==========================================================
// Parallel port stereo DAC
// Strobe bit 0 rising loads left, falling loads right
//==========================================================

`timescale 1ns/10ps
`default_nettype none

module lpt_dac
	import samc_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       lptd_wr_stb,
	input  logic       lpts_wr_stb,
	input  port_byte_t cpu_dout,
	output port_byte_t vox_l,
	output port_byte_t vox_r
);

	port_byte_t data;
	logic       old_stb;

	// Data latch
	always_ff @(posedge clk_sys) begin
		if (lptd_wr_stb)
			data <= cpu_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vox_l   <= '0;
			vox_r   <= '0;
			old_stb <= 1'b0;
		end else if (lpts_wr_stb) begin
			if (!old_stb && cpu_dout[0])
				vox_l <= data;
			if (old_stb && !cpu_dout[0])
				vox_r <= data;
			old_stb <= cpu_dout[0];
		end
	end

endmodule

`default_nettype wire

/* hdl/audio_mixer.sv */
//==========================================================
// Beeper, DAC and SID mix into unsigned 16-bit samples
// SID fades in and out through a soft muter on ce_1m
//==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "samc_defines.svh"

module audio_mixer
	import samc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ce_1m,
	input  logic        ear,
	input  logic        sid_active,
	input  port_byte_t  vox_l,
	input  port_byte_t  vox_r,
	input  sid_sample_t sid_sample,
	output audio_t      audio_l,
	output audio_t      audio_r
);

	localparam logic [17:0] mute_step = 18'(`SAMC_MUTE_STEP);

	logic [17:0] att;
	logic [17:0] sid_unsigned;
	logic [17:0] sid_muted;
	logic [18:0] beeper;
	logic [18:0] aud_l;
	logic [18:0] aud_r;

	//==========================================================
	// Soft muter
	//==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset)
			att <= '1;
		else if (ce_1m) begin
			if (sid_active)
				att <= (att > mute_step) ? att - mute_step : '0;
			else
				att <= (att < ~mute_step) ? att + mute_step : '1;
		end
	end

	// Offset binary, then attenuate with a floor at zero
	assign sid_unsigned = {!sid_sample[17], sid_sample[16:0]};
	assign sid_muted    = (sid_unsigned > att) ? sid_unsigned - att : '0;

	//==========================================================
	// Mix
	//==========================================================
	assign beeper = {1'b0, ear, 17'd0};
	assign aud_l  = {1'b0, vox_l, vox_l, 2'b00} + beeper + {1'b0, sid_muted};
	assign aud_r  = {1'b0, vox_r, vox_r, 2'b00} + beeper + {1'b0, sid_muted};

	assign audio_l = aud_l[18:3];
	assign audio_r = aud_r[18:3];

endmodule

`default_nettype wire

/* hdl/samc_asic.sv */
//==========================================================
// SAM Coupe ASIC glue, single clock domain on clk_sys
// The 6 MHz enable is not brought out
//==========================================================

`timescale 1ns/10ps
`default_nettype none

module samc_asic
	import samc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  port_byte_t  cpu_dout,
	input  logic        m1_n,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        rfsh_n,
	input  cpu_speed_t  speed_req,
	input  logic        mem_contention,
	input  logic        io_contention,
	input  logic        ram_busy,
	input  logic        ext_ram_off,
	input  sid_sample_t sid_sample,
	input  logic        sid_active,
	output logic        ce_cpu_p,
	output logic        ce_cpu_n,
	output logic        ce_1m,
	output port_byte_t  asic_dout,
	output ram_page_t   ram_page,
	output logic        rom_sel,
	output logic        ram_we,
	output logic        ram_rd,
	output logic        midi_tx,
	output logic        int_midi,
	output audio_t      audio_l,
	output audio_t      audio_r
);

	port_byte_t lmpr;
	port_byte_t hmpr;
	port_byte_t ext_c;
	port_byte_t ext_d;
	port_byte_t vox_l;
	port_byte_t vox_r;
	logic       ear;
	logic       ram_acc;
	logic       midi_wr_stb;
	logic       lptd_wr_stb;
	logic       lpts_wr_stb;

	cpu_clock_gen i_cpu_clock_gen (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.speed_req      (speed_req),
		.rd_n           (rd_n),
		.wr_n           (wr_n),
		.iorq_n         (iorq_n),
		.m1_n           (m1_n),
		.ram_acc        (ram_acc),
		.mem_contention (mem_contention),
		.io_contention  (io_contention),
		.ram_busy       (ram_busy),
		.addr_hi5       (addr[7:3]),
		.ce_cpu_p       (ce_cpu_p),
		.ce_cpu_n       (ce_cpu_n),
		.ce_1m          (ce_1m),
		.ce_6m          ()
	);

	asic_ports i_asic_ports (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.iorq_n      (iorq_n),
		.wr_n        (wr_n),
		.m1_n        (m1_n),
		.addr        (addr),
		.cpu_dout    (cpu_dout),
		.int_midi    (int_midi),
		.lmpr        (lmpr),
		.hmpr        (hmpr),
		.ext_c       (ext_c),
		.ext_d       (ext_d),
		.ear         (ear),
		.midi_wr_stb (midi_wr_stb),
		.lptd_wr_stb (lptd_wr_stb),
		.lpts_wr_stb (lpts_wr_stb),
		.asic_dout   (asic_dout)
	);

	memory_pager i_memory_pager (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ext_ram_off (ext_ram_off),
		.mreq_n      (mreq_n),
		.rd_n        (rd_n),
		.wr_n        (wr_n),
		.rfsh_n      (rfsh_n),
		.addr        (addr),
		.lmpr        (lmpr),
		.hmpr        (hmpr),
		.ext_c       (ext_c),
		.ext_d       (ext_d),
		.ram_page    (ram_page),
		.rom_sel     (rom_sel),
		.ram_we      (ram_we),
		.ram_rd      (ram_rd),
		.ram_acc     (ram_acc)
	);

	midi_tx_timer i_midi_tx_timer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ce_1m       (ce_1m),
		.midi_wr_stb (midi_wr_stb),
		.midi_tx     (midi_tx),
		.int_midi    (int_midi)
	);

	lpt_dac i_lpt_dac (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.lptd_wr_stb (lptd_wr_stb),
		.lpts_wr_stb (lpts_wr_stb),
		.cpu_dout    (cpu_dout),
		.vox_l       (vox_l),
		.vox_r       (vox_r)
	);

	audio_mixer i_audio_mixer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ce_1m      (ce_1m),
		.ear        (ear),
		.sid_active (sid_active),
		.vox_l      (vox_l),
		.vox_r      (vox_r),
		.sid_sample (sid_sample),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

endmodule

`default_nettype wire

/* sim/samc_asic_properties.sv */
//==========================================================
// Concurrent checks on the clock enables and MIDI interrupt
// CPU gap checks skip intervals with stalls, contention or
// a change of speed_req, and the interval right after one
//==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "samc_defines.svh"

module samc_asic_properties
	import samc_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_speed_t speed_req,
	input  logic       mem_contention,
	input  logic       io_contention,
	input  logic       ram_busy,
	input  logic       ce_cpu_p,
	input  logic       ce_cpu_n,
	input  logic       ce_1m,
	input  logic       midi_tx,
	input  logic       int_midi
);

	logic [6:0] gap_1m;
	logic       seen_1m;
	logic [7:0] gap_cpu;
	cpu_speed_t last_speed;
	logic       dirty;
	logic       prev_clean;
	logic       disturb;
	logic       clean_now;
	logic [8:0] midi_ticks;
	logic       fail_1m = 1'b0;
	logic       fail_cpu_p = 1'b0;
	logic       fail_cpu_n = 1'b0;
	logic       fail_midi = 1'b0;
	logic       prop_fail;

	// CPU cycle length in clk_sys cycles, max count plus one
	function automatic logic [7:0] cpu_period(input cpu_speed_t s);
		case (s)
			3'd0:       return 8'd27;
			3'd1, 3'd2: return 8'd16;
			3'd3:       return 8'd10;
			3'd4:       return 8'd8;
			default:    return 8'd4;
		endcase
	endfunction

	// Offset of ce_cpu_n behind ce_cpu_p
	function automatic logic [7:0] cpu_mid(input cpu_speed_t s);
		case (s)
			3'd0:       return 8'd13;
			3'd1, 3'd2: return 8'd8;
			3'd3:       return 8'd5;
			3'd4:       return 8'd4;
			default:    return 8'd2;
		endcase
	endfunction

	assign disturb   = ram_busy || mem_contention || io_contention || (speed_req != last_speed);
	assign clean_now = prev_clean && !dirty && !disturb;
	assign prop_fail = fail_1m || fail_cpu_p || fail_cpu_n || fail_midi;

	//==========================================================
	// Gap counters
	//==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gap_1m     <= '0;
			seen_1m    <= 1'b0;
			gap_cpu    <= '0;
			dirty      <= 1'b1;
			prev_clean <= 1'b0;
			midi_ticks <= '0;
		end else begin
			if (ce_1m) begin
				gap_1m  <= 7'd1;
				seen_1m <= 1'b1;
			end else if (gap_1m != 7'h7F)
				gap_1m <= gap_1m + 7'd1;
			if (ce_cpu_p) begin
				gap_cpu    <= 8'd1;
				prev_clean <= !dirty && !disturb;
				dirty      <= 1'b0;
			end else begin
				if (gap_cpu != 8'hFF)
					gap_cpu <= gap_cpu + 8'd1;
				if (disturb)
					dirty <= 1'b1;
			end
			// 1 MHz ticks since midi_tx rose
			if (!midi_tx)
				midi_ticks <= '0;
			else if (ce_1m)
				midi_ticks <= midi_ticks + 9'd1;
		end
		last_speed <= speed_req;
	end

	//==========================================================
	// Assertions
	//==========================================================
	a_1m_gap: assert property (@(posedge clk_sys) disable iff (reset)
		(ce_1m && seen_1m) |-> (gap_1m == 7'(`SAMC_MEG_DIV)))
		else begin
			fail_1m = 1'b1;
			$error("FAILED at %0t: ce_1m came %0d cycles after the previous one",
				$time, gap_1m);
		end

	a_cpu_p_gap: assert property (@(posedge clk_sys) disable iff (reset)
		(ce_cpu_p && clean_now) |-> (gap_cpu == cpu_period(speed_req)))
		else begin
			fail_cpu_p = 1'b1;
			$error("FAILED at %0t: ce_cpu_p spacing %0d at speed %0d",
				$time, gap_cpu, speed_req);
		end

	a_cpu_n_mid: assert property (@(posedge clk_sys) disable iff (reset)
		(ce_cpu_n && clean_now) |-> (gap_cpu == cpu_mid(speed_req)))
		else begin
			fail_cpu_n = 1'b1;
			$error("FAILED at %0t: ce_cpu_n offset %0d at speed %0d",
				$time, gap_cpu, speed_req);
		end

	// Interrupt rises with INT_AT plus one ticks of the byte left
	a_midi_int: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(int_midi) |->
			(midi_tx && (midi_ticks == 9'(`SAMC_MIDI_TX_TIME - `SAMC_MIDI_INT_AT))))
		else begin
			fail_midi = 1'b1;
			$error("FAILED at %0t: int_midi rose after %0d ticks of midi_tx",
				$time, midi_ticks);
		end

endmodule

bind samc_asic samc_asic_properties i_samc_asic_properties (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.speed_req      (speed_req),
	.mem_contention (mem_contention),
	.io_contention  (io_contention),
	.ram_busy       (ram_busy),
	.ce_cpu_p       (ce_cpu_p),
	.ce_cpu_n       (ce_cpu_n),
	.ce_1m          (ce_1m),
	.midi_tx        (midi_tx),
	.int_midi       (int_midi)
);

`default_nettype wire

/* sim/tb_samc_asic.sv */
//==========================================================
// Testbench for the ASIC glue, Z80 bus cycles by task
// Contention, ram_busy, ext_ram_off and sid_active stay low
//==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "samc_defines.svh"

module tb_samc_asic
	import samc_pkg::*;
();

	localparam int clk_half = 50;
	// One MIDI byte is about 30720 cycles, everything else is far shorter
	localparam int watchdog_cycles = 60000;
	localparam int midi_ticks = `SAMC_MIDI_TX_TIME + 1;
	localparam int int_ticks_exp = `SAMC_MIDI_INT_AT + 1;

	logic        clk_sys;
	logic        reset;
	logic [15:0] addr;
	port_byte_t  cpu_dout;
	logic        m1_n;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        rfsh_n;
	cpu_speed_t  speed_req;
	logic        mem_contention;
	logic        io_contention;
	logic        ram_busy;
	logic        ext_ram_off;
	sid_sample_t sid_sample;
	logic        sid_active;
	logic        ce_cpu_p;
	logic        ce_cpu_n;
	logic        ce_1m;
	port_byte_t  asic_dout;
	ram_page_t   ram_page;
	logic        rom_sel;
	logic        ram_we;
	logic        ram_rd;
	logic        midi_tx;
	logic        int_midi;
	audio_t      audio_l;
	audio_t      audio_r;

	// Expected register state, kept by the write task
	port_byte_t lmpr_m;
	port_byte_t hmpr_m;
	port_byte_t ext_c_m;
	port_byte_t ext_d_m;
	port_byte_t lpt_data_m;
	port_byte_t vox_l_m;
	port_byte_t vox_r_m;
	logic       ear_m;
	logic       old_stb_m;

	samc_asic i_samc_asic (.*);

	initial begin
		clk_sys = 1'b0;
		forever #clk_half clk_sys = ~clk_sys;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Timeout: tests did not finish within %0d clock cycles", watchdog_cycles);
		$display("TEST FAILED");
		$fatal(1);
	end

	always @(negedge clk_sys) begin
		if (i_samc_asic.i_samc_asic_properties.prop_fail) begin
			$display("A bound assertion on the DUT failed");
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	//==========================================================
	// Reference models
	//==========================================================
	function automatic port_byte_t status_byte(input logic irq);
		return {3'b111, ~irq, 4'hF};
	endfunction

	function automatic ram_page_t page_model(input logic [15:0] a);
		page_t base;
		if (hmpr_m[7] && a[15])
			return a[14] ? {1'b1, ext_d_m} : {1'b1, ext_c_m};
		base = a[15] ? hmpr_m[4:0] : lmpr_m[4:0];
		if (a[14])
			base = base + 5'd1;
		return {4'd0, base};
	endfunction

	function automatic audio_t mix_model(input port_byte_t vox, input logic beep,
		input logic [17:0] att);
		int sid_u;
		int muted;
		int sum;
		// Offset binary SID, attenuated with a floor at zero
		sid_u = int'(sid_sample ^ 18'h20000);
		muted = (sid_u > int'(att)) ? sid_u - int'(att) : 0;
		// Byte doubled into bits 17 to 2 is the byte times 1028
		sum = int'(vox) * 1028 + (beep ? 131072 : 0) + muted;
		return audio_t'(sum >> 3);
	endfunction

	task automatic update_model(input logic [7:0] port, input port_byte_t data);
		case (port)
			8'(`SAMC_PORT_LMPR):     lmpr_m = data;
			8'(`SAMC_PORT_HMPR):     hmpr_m = data;
			8'(`SAMC_PORT_EXT_C):    ext_c_m = data;
			8'(`SAMC_PORT_EXT_D):    ext_d_m = data;
			8'(`SAMC_PORT_BORDER):   ear_m = data[4];
			8'(`SAMC_PORT_LPT_DATA): lpt_data_m = data;
			8'(`SAMC_PORT_LPT_STB): begin
				if (!old_stb_m && data[0])
					vox_l_m = lpt_data_m;
				if (old_stb_m && !data[0])
					vox_r_m = lpt_data_m;
				old_stb_m = data[0];
			end
			default: ;
		endcase
	endtask

	//==========================================================
	// Bus cycles
	//==========================================================
	task automatic io_write(input logic [7:0] port, input port_byte_t data);
		@(posedge clk_sys);
		addr     <= {8'h00, port};
		cpu_dout <= data;
		iorq_n   <= 1'b0;
		wr_n     <= 1'b0;
		repeat (2) @(posedge clk_sys);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		update_model(port, data);
		@(posedge clk_sys);
	endtask

	task automatic io_read_check(input logic [7:0] port, input port_byte_t exp);
		@(posedge clk_sys);
		addr   <= {8'h00, port};
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		@(negedge clk_sys);
		check_value($sformatf("read of port %0d", port), 32'(asic_dout), 32'(exp));
		@(posedge clk_sys);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	task automatic mem_cycle(input logic [15:0] a, input logic is_write);
		logic rom_m;
		logic wp_m;
		rom_m = (!lmpr_m[5] && a[15:14] == 2'd0) || (lmpr_m[6] && a[15:14] == 2'd3);
		wp_m  = lmpr_m[7] && a[15:14] == 2'd0;
		@(posedge clk_sys);
		addr   <= a;
		mreq_n <= 1'b0;
		if (is_write)
			wr_n <= 1'b0;
		else
			rd_n <= 1'b0;
		@(negedge clk_sys);
		check_value($sformatf("ram_page at %h", a), 32'(ram_page), 32'(page_model(a)));
		check_value($sformatf("rom_sel at %h", a), 32'(rom_sel), 32'(rom_m));
		check_value($sformatf("ram_we at %h", a), 32'(ram_we),
			32'(is_write && !rom_m && !wp_m));
		check_value($sformatf("ram_rd at %h", a), 32'(ram_rd), 32'(!is_write && !rom_m));
		@(posedge clk_sys);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic audio_check();
		@(negedge clk_sys);
		// Muter stays at full attenuation while sid_active is low
		check_value("audio_l", 32'(audio_l), 32'(mix_model(vox_l_m, ear_m, 18'h3FFFF)));
		check_value("audio_r", 32'(audio_r), 32'(mix_model(vox_r_m, ear_m, 18'h3FFFF)));
	endtask

	task automatic midi_byte_check();
		int   tx_ticks;
		int   int_ticks;
		logic int_exp;
		tx_ticks  = 0;
		int_ticks = 0;
		io_write(8'(`SAMC_PORT_MIDI), 8'h90);
		// Address parked on the status port for the whole byte
		@(posedge clk_sys);
		addr <= {8'h00, 8'(`SAMC_PORT_STATUS)};
		@(negedge clk_sys);
		while (!midi_tx)
			@(negedge clk_sys);
		while (midi_tx) begin
			// Interrupt due once only the last ticks of the byte remain
			int_exp = (tx_ticks >= midi_ticks - int_ticks_exp);
			check_value("int_midi during MIDI", 32'(int_midi), 32'(int_exp));
			check_value("status during MIDI", 32'(asic_dout), 32'(status_byte(int_exp)));
			if (ce_1m) begin
				tx_ticks++;
				if (int_midi)
					int_ticks++;
			end
			@(negedge clk_sys);
		end
		check_value("ce_1m ticks with midi_tx high", 32'(tx_ticks), 32'(midi_ticks));
		check_value("ce_1m ticks with int_midi high", 32'(int_ticks), 32'(int_ticks_exp));
	endtask

	task automatic speed_run(input cpu_speed_t s);
		int pulses;
		pulses = 0;
		@(posedge clk_sys);
		speed_req <= s;
		while (pulses < 8) begin
			@(negedge clk_sys);
			if (ce_cpu_p)
				pulses++;
		end
	endtask

	//==========================================================
	// Test sequence
	//==========================================================
	initial begin
		reset = 1'b1;
		addr = '0;
		cpu_dout = '0;
		m1_n = 1'b1;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		rfsh_n = 1'b1;
		speed_req = '0;
		mem_contention = 1'b0;
		io_contention = 1'b0;
		ram_busy = 1'b0;
		ext_ram_off = 1'b0;
		sid_sample = 18'h24A5C;
		sid_active = 1'b0;
		lmpr_m = '0;
		hmpr_m = '0;
		ext_c_m = '0;
		ext_d_m = '0;
		lpt_data_m = '0;
		vox_l_m = '0;
		vox_r_m = '0;
		ear_m = 1'b0;
		old_stb_m = 1'b0;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);

		// Register read-back and idle status
		io_write(8'(`SAMC_PORT_LMPR), 8'h23);
		io_write(8'(`SAMC_PORT_HMPR), 8'h0A);
		io_read_check(8'(`SAMC_PORT_LMPR), 8'h23);
		io_read_check(8'(`SAMC_PORT_HMPR), 8'h0A);
		io_read_check(8'(`SAMC_PORT_STATUS), status_byte(1'b0));
		io_read_check(8'(`SAMC_PORT_LPT_DATA), 8'h00);
		io_read_check(8'h10, 8'hFF);

		// Paging, ROM select and write protect
		io_write(8'(`SAMC_PORT_LMPR), 8'h03);
		mem_cycle(16'h1234, 1'b0);
		mem_cycle(16'h1234, 1'b1);
		mem_cycle(16'h5678, 1'b1);
		mem_cycle(16'h9ABC, 1'b0);
		mem_cycle(16'hDEF0, 1'b1);
		io_write(8'(`SAMC_PORT_LMPR), 8'hA5);
		mem_cycle(16'h0100, 1'b1);
		mem_cycle(16'h0100, 1'b0);
		mem_cycle(16'h4100, 1'b1);
		io_write(8'(`SAMC_PORT_LMPR), 8'h5F);
		io_write(8'(`SAMC_PORT_HMPR), 8'h1F);
		mem_cycle(16'h7FFF, 1'b1);
		mem_cycle(16'hC000, 1'b0);
		mem_cycle(16'hC000, 1'b1);

		// External RAM above 8000h
		io_write(8'(`SAMC_PORT_EXT_C), 8'h5A);
		io_write(8'(`SAMC_PORT_EXT_D), 8'hC3);
		io_write(8'(`SAMC_PORT_LMPR), 8'h22);
		io_write(8'(`SAMC_PORT_HMPR), 8'h86);
		mem_cycle(16'h8123, 1'b1);
		mem_cycle(16'hC456, 1'b0);
		mem_cycle(16'h4000, 1'b0);

		// DAC capture and beeper mix
		io_write(8'(`SAMC_PORT_LPT_DATA), 8'h3C);
		io_write(8'(`SAMC_PORT_LPT_STB), 8'h01);
		io_write(8'(`SAMC_PORT_LPT_DATA), 8'h81);
		io_write(8'(`SAMC_PORT_LPT_STB), 8'h00);
		io_write(8'(`SAMC_PORT_BORDER), 8'h17);
		audio_check();
		io_write(8'(`SAMC_PORT_LPT_DATA), 8'hF0);
		io_write(8'(`SAMC_PORT_LPT_STB), 8'h01);
		io_write(8'(`SAMC_PORT_LPT_DATA), 8'h11);
		io_write(8'(`SAMC_PORT_LPT_STB), 8'h01);
		io_write(8'(`SAMC_PORT_BORDER), 8'h0F);
		audio_check();

		midi_byte_check();

		// Enable spacing is checked by the bound assertions
		for (int s = 0; s < 6; s++)
			speed_run(cpu_speed_t'(s));

		if (!i_samc_asic.i_samc_asic_properties.prop_fail) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* samc_asic.f */
+incdir+hdl
hdl/samc_pkg.sv
hdl/cpu_clock_gen.sv
hdl/asic_ports.sv
hdl/memory_pager.sv
hdl/midi_tx_timer.sv
hdl/lpt_dac.sv
hdl/audio_mixer.sv
hdl/samc_asic.sv
sim/samc_asic_properties.sv
sim/tb_samc_asic.sv

/* Makefile */
# Verilator build and run of the SAM Coupe ASIC glue testbench

VERILATOR ?= verilator
TOP       ?= tb_samc_asic
FILELIST  ?= samc_asic.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+10

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
